//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := regbus_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/regbus_tb.sv
// Testbench for the register bus: clock, reset, random host cycles, model and checks
`timescale 1ns/10ps
`default_nettype none

module regbus_tb;

   localparam int RESP_TIMEOUT = 20;

   logic                              clk_125 = 1'b0;
   logic                              core_rst_n;
   logic                              cyc_i;
   logic                              stb_i;
   logic                              we_i;
   logic [regbus_pkg::HOST_ADR_W-1:0] adr_i;
   logic [regbus_pkg::HOST_DAT_W-1:0] dat_i;
   logic [regbus_pkg::HOST_SEL_W-1:0] sel_i;
   logic                              ack_o;
   logic                              err_o;
   logic [regbus_pkg::HOST_DAT_W-1:0] dat_o;

   int seed;

   // Model state per bank
   logic [regbus_pkg::WORD_W-1:0]     model_mem [regbus_pkg::NUM_REGIONS][regbus_pkg::BANK_WORDS];
   logic [regbus_pkg::HOST_DAT_W-1:0] model_half [regbus_pkg::NUM_REGIONS];
   logic [regbus_pkg::HOST_SEL_W-1:0] model_sel [regbus_pkg::NUM_REGIONS];

   regbus_top i_regbus_top (
      .clk_125    (clk_125),
      .core_rst_n (core_rst_n),
      .cyc_i      (cyc_i),
      .stb_i      (stb_i),
      .we_i       (we_i),
      .adr_i      (adr_i),
      .dat_i      (dat_i),
      .sel_i      (sel_i),
      .ack_o      (ack_o),
      .err_o      (err_o),
      .dat_o      (dat_o)
   );

   always #20 clk_125 = ~clk_125;

   // ****************************************
   // Reporting
   // ****************************************

   task automatic stop_on_error();
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
         stop_on_error();
      end
   endtask

   // ****************************************
   // Address helpers
   // ****************************************

   // -1 when the address lies outside every region
   function automatic int region_of(input logic [regbus_pkg::HOST_ADR_W-1:0] adr);
      int hit;
      hit = -1;
      for (int r = 0; r < regbus_pkg::NUM_REGIONS; r++) begin
         if (adr >= regbus_pkg::REGION_BASE[r] &&
             adr < regbus_pkg::REGION_BASE[r] + regbus_pkg::BANK_BYTES) begin
            hit = r;
         end
      end
      return hit;
   endfunction

   function automatic logic [19:0] mapped_addr(input int r, input logic [3:0] w, input logic hi);
      return regbus_pkg::REGION_BASE[r] + {14'd0, w, hi, 1'b0};
   endfunction

   // All bases have bit 19 clear
   function automatic logic [19:0] unmapped_addr();
      logic [19:0] a;
      a = 20'($random(seed));
      if (region_of(a) >= 0) begin
         a[19] = 1'b1;
      end
      return a;
   endfunction

   // ****************************************
   // Reference model
   // ****************************************

   task automatic model_access(input logic we, input logic [19:0] adr, input logic [15:0] dat,
                               input logic [1:0] sel, output logic exp_ack,
                               output logic exp_err, output logic [15:0] exp_dat);
      int          r;
      logic [3:0]  w;
      logic        hi;
      logic [31:0] word;
      r       = region_of(adr);
      w       = adr[5:2];
      hi      = adr[1];
      exp_dat = 16'd0;
      exp_ack = (r >= 0);
      exp_err = (r < 0);
      if (r >= 0) begin
         word = model_mem[r][w];
         if (we && !hi) begin
            model_half[r] = dat;
            model_sel[r]  = sel;
         end else if (we) begin
            // Low bytes from the held half, high bytes from this cycle
            if (model_sel[r][0]) word[7:0]   = model_half[r][7:0];
            if (model_sel[r][1]) word[15:8]  = model_half[r][15:8];
            if (sel[0])          word[23:16] = dat[7:0];
            if (sel[1])          word[31:24] = dat[15:8];
            model_mem[r][w] = word;
         end else if (!hi) begin
            exp_dat       = word[15:0];
            model_half[r] = word[31:16];
         end else begin
            exp_dat = model_half[r];
         end
      end
   endtask

   // ****************************************
   // Host cycles
   // ****************************************

   task automatic bus_cycle(input logic we, input logic [19:0] adr, input logic [15:0] dat,
                            input logic [1:0] sel, output logic got_ack,
                            output logic got_err, output logic [15:0] got_dat);
      int cycles;
      @(negedge clk_125);
      cyc_i  = 1'b1;
      stb_i  = 1'b1;
      we_i   = we;
      adr_i  = adr;
      dat_i  = dat;
      sel_i  = sel;
      cycles = 0;
      do begin
         @(negedge clk_125);
         cycles++;
      end while (!ack_o && !err_o && cycles < RESP_TIMEOUT);
      if (!ack_o && !err_o) begin
         $display("No response arrived for the host request at address 0x%h", adr);
         stop_on_error();
      end
      got_ack = ack_o;
      got_err = err_o;
      got_dat = dat_o;
      check_value("response latency", cycles, 1);
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic do_request(input logic we, input logic [19:0] adr, input logic [15:0] dat,
                             input logic [1:0] sel);
      logic        exp_ack;
      logic        exp_err;
      logic [15:0] exp_dat;
      logic        got_ack;
      logic        got_err;
      logic [15:0] got_dat;
      model_access(we, adr, dat, sel, exp_ack, exp_err, exp_dat);
      bus_cycle(we, adr, dat, sel, got_ack, got_err, got_dat);
      check_value("ack_o", {31'd0, got_ack}, {31'd0, exp_ack});
      check_value("err_o", {31'd0, got_err}, {31'd0, exp_err});
      if (!we && exp_ack) begin
         check_value("dat_o", {16'd0, got_dat}, {16'd0, exp_dat});
      end
   endtask

   task automatic read_half(input int r, input logic [3:0] w, input logic hi);
      do_request(1'b0, mapped_addr(r, w, hi), 16'd0, 2'b00);
   endtask

   task automatic write_half(input int r, input logic [3:0] w, input logic hi,
                             input logic [15:0] dat, input logic [1:0] sel);
      do_request(1'b1, mapped_addr(r, w, hi), dat, sel);
   endtask

   // ****************************************
   // Stimulus
   // ****************************************

   initial begin
      logic [3:0]  w;
      logic [31:0] rnd;
      seed       = 32'h3b834858;
      core_rst_n = 1'b0;
      cyc_i      = 1'b0;
      stb_i      = 1'b0;
      we_i       = 1'b0;
      adr_i      = '0;
      dat_i      = '0;
      sel_i      = '0;
      for (int r = 0; r < regbus_pkg::NUM_REGIONS; r++) begin
         model_half[r] = '0;
         model_sel[r]  = '0;
         for (int k = 0; k < regbus_pkg::BANK_WORDS; k++) begin
            model_mem[r][k] = '0;
         end
      end
      repeat (5) @(posedge clk_125);
      @(negedge clk_125);
      core_rst_n = 1'b1;

      // Zero after reset
      for (int r = 0; r < regbus_pkg::NUM_REGIONS; r++) begin
         w = 4'($random(seed));
         read_half(r, w, 1'b0);
         read_half(r, w, 1'b1);
      end

      // Full word through both halves
      for (int r = 0; r < regbus_pkg::NUM_REGIONS; r++) begin
         w = 4'($random(seed));
         write_half(r, w, 1'b0, 16'($random(seed)), 2'b11);
         write_half(r, w, 1'b1, 16'($random(seed)), 2'b11);
         read_half(r, w, 1'b0);
         read_half(r, w, 1'b1);
      end

      // Partial byte enables
      for (int r = 0; r < regbus_pkg::NUM_REGIONS; r++) begin
         for (int k = 0; k < 4; k++) begin
            w = 4'($random(seed));
            write_half(r, w, 1'b0, 16'($random(seed)), 2'($random(seed)));
            write_half(r, w, 1'b1, 16'($random(seed)), 2'($random(seed)));
            read_half(r, w, 1'b0);
            read_half(r, w, 1'b1);
         end
      end

      // Shared half latch across words, reads and writes
      for (int r = 0; r < regbus_pkg::NUM_REGIONS; r++) begin
         write_half(r, 4'd5, 1'b0, 16'($random(seed)), 2'b11);
         write_half(r, 4'd5, 1'b1, 16'($random(seed)), 2'b11);
         write_half(r, 4'd3, 1'b0, 16'($random(seed)), 2'b11);
         write_half(r, 4'd7, 1'b1, 16'($random(seed)), 2'b11);
         read_half(r, 4'd7, 1'b0);
         read_half(r, 4'd5, 1'b0);
         write_half(r, 4'd9, 1'b1, 16'($random(seed)), 2'b11);
         read_half(r, 4'd9, 1'b0);
         read_half(r, 4'd9, 1'b1);
         read_half(r, 4'd2, 1'b0);
         write_half(r, 4'd2, 1'b1, 16'($random(seed)), 2'b11);
         read_half(r, 4'd2, 1'b1);
      end

      // Unmapped cycles leave every bank alone
      for (int r = 0; r < regbus_pkg::NUM_REGIONS; r++) begin
         do_request(1'b1, regbus_pkg::REGION_BASE[r] + regbus_pkg::BANK_BYTES,
                    16'($random(seed)), 2'b11);
         do_request(1'b0, unmapped_addr(), 16'd0, 2'b00);
      end
      for (int r = 0; r < regbus_pkg::NUM_REGIONS; r++) begin
         write_half(r, 4'd0, 1'b1, 16'($random(seed)), 2'b11);
         for (int k = 0; k < regbus_pkg::BANK_WORDS; k++) begin
            read_half(r, 4'(k), 1'b0);
            read_half(r, 4'(k), 1'b1);
         end
      end

      // Random mix, one in eight unmapped
      for (int n = 0; n < 400; n++) begin
         rnd = $random(seed);
         if (rnd[2:0] == 3'd0) begin
            do_request(rnd[10], unmapped_addr(), rnd[31:16], rnd[12:11]);
         end else begin
            do_request(rnd[10], mapped_addr(int'(rnd[4:3]), rnd[8:5], rnd[9]),
                       rnd[31:16], rnd[12:11]);
         end
      end

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/regbus_addr_decode.sv
// Region decoder for host cycles: per-bank strobes, word index, half select
`timescale 1ns/10ps
`default_nettype none

module regbus_addr_decode (
   input  wire logic [regbus_pkg::HOST_ADR_W-1:0]  adr_i,
   input  wire logic                               stb_i,
   input  wire logic                               cyc_i,
   output logic      [regbus_pkg::NUM_REGIONS-1:0] bank_stb_o,
   output logic      [regbus_pkg::WORD_IDX_W-1:0]  word_idx_o,
   output logic                                    hi_half_o,
   output logic                                    unmapped_o
);

   logic                               strobe;
   logic [regbus_pkg::NUM_REGIONS-1:0] hit;
   logic [regbus_pkg::HOST_ADR_W-1:0]  region_mask;

   assign strobe = cyc_i & stb_i;

   // Clears the offset bits inside one bank span
   assign region_mask = ~(regbus_pkg::BANK_BYTES - 1'b1);

   always_comb begin
      for (int r = 0; r < regbus_pkg::NUM_REGIONS; r++) begin
         hit[r] = (adr_i & region_mask) == regbus_pkg::REGION_BASE[r];
      end
   end

   assign bank_stb_o = hit & {regbus_pkg::NUM_REGIONS{strobe}};
   assign unmapped_o = strobe & ~(|hit);

   // Word index follows the half select bit
   assign word_idx_o = adr_i[regbus_pkg::HALF_BIT+1 +: regbus_pkg::WORD_IDX_W];
   assign hi_half_o  = adr_i[regbus_pkg::HALF_BIT];

   // ****************************************
   // Checks
   // ****************************************

   // Region map must not overlap
   always_comb begin
      assert ($onehot0(bank_stb_o))
         else $error("more than one bank strobed for address %h", adr_i);
   end

endmodule

`default_nettype wire

//--- rtl/regbus_half_word_bank.sv
// Word bank with 16-bit half access, shared half latch and held byte enables
`timescale 1ns/10ps
`default_nettype none

module regbus_half_word_bank (
   input  wire logic                              clk_125,
   input  wire logic                              core_rst_n,
   input  wire logic                              stb_i,
   input  wire logic                              we_i,
   input  wire logic [regbus_pkg::WORD_IDX_W-1:0] word_idx_i,
   input  wire logic                              hi_half_i,
   input  wire logic [regbus_pkg::HOST_DAT_W-1:0] dat_i,
   input  wire logic [regbus_pkg::HOST_SEL_W-1:0] sel_i,
   output logic                                   ack_o,
   output logic      [regbus_pkg::HOST_DAT_W-1:0] dat_o
);

   logic [regbus_pkg::WORD_W-1:0]     mem [regbus_pkg::BANK_WORDS];
   logic [regbus_pkg::HOST_DAT_W-1:0] half_q;
   logic [regbus_pkg::HOST_SEL_W-1:0] sel_q;
   logic                              ack_q;
   logic [regbus_pkg::HOST_DAT_W-1:0] dat_q;
   logic                              req;
   logic [regbus_pkg::WORD_W-1:0]     rd_word;
   logic [regbus_pkg::WORD_SEL_W-1:0] word_sel;
   logic [regbus_pkg::WORD_W-1:0]     word_new;

   // Strobe is ignored while the previous request is acknowledged
   assign req = stb_i & ~ack_q;

   assign rd_word = mem[word_idx_i];

   // Upper bytes from the bus, lower bytes from the half latch
   assign word_sel = {sel_i, sel_q};
   assign word_new = {dat_i, half_q};

   // ****************************************
   // Control, half latch and word array
   // ****************************************

   always_ff @(posedge clk_125 or negedge core_rst_n) begin
      if (!core_rst_n) begin
         ack_q  <= 1'b0;
         half_q <= '0;
         sel_q  <= '0;
         for (int w = 0; w < regbus_pkg::BANK_WORDS; w++) begin
            mem[w] <= '0;
         end
      end else begin
         ack_q <= req;
         if (req) begin
            if (we_i && !hi_half_i) begin
               // Low half only parks in the latch
               half_q <= dat_i;
               sel_q  <= sel_i;
            end else if (we_i) begin
               for (int b = 0; b < regbus_pkg::WORD_SEL_W; b++) begin
                  if (word_sel[b]) begin
                     mem[word_idx_i][b*8 +: 8] <= word_new[b*8 +: 8];
                  end
               end
            end else if (!hi_half_i) begin
               // Capture upper half for the following high read
               half_q <= rd_word[regbus_pkg::WORD_W-1:regbus_pkg::HOST_DAT_W];
            end
         end
      end
   end

   // ****************************************
   // Read data
   // ****************************************

   always_ff @(posedge clk_125) begin
      if (req) begin
         if (we_i) begin
            dat_q <= '0;
         end else if (hi_half_i) begin
            dat_q <= half_q;
         end else begin
            dat_q <= rd_word[regbus_pkg::HOST_DAT_W-1:0];
         end
      end
   end

   assign ack_o = ack_q;
   assign dat_o = dat_q;

   // Host drops its strobe after every acknowledge
   ack_single : assert property (
      @(posedge clk_125) disable iff (!core_rst_n)
      ack_o |=> !ack_o
   ) else $error("bank ack held for two cycles");

endmodule

`default_nettype wire

//--- rtl/regbus_pkg.sv
// Register bus widths, region map and bank geometry
`default_nettype none

package regbus_pkg;

   // ****************************************
   // Host bus
   // ****************************************

   // Byte address width of the host cycle
   localparam int HOST_ADR_W = 20;
   localparam int HOST_DAT_W = 16;
   localparam int HOST_SEL_W = 2;

   // ****************************************
   // Bank word
   // ****************************************

   localparam int WORD_W     = 32;
   localparam int WORD_SEL_W = 4;

   // ****************************************
   // Region map
   // ****************************************

   localparam int NUM_REGIONS = 4;

   // Entry 0 is the lowest region
   localparam logic [NUM_REGIONS-1:0][HOST_ADR_W-1:0] REGION_BASE = {
      20'h10000,
      20'h04000,
      20'h02000,
      20'h00000
   };

   // Bank geometry, 16 words of 4 bytes
   localparam int BANK_WORDS = 16;
   localparam logic [HOST_ADR_W-1:0] BANK_BYTES = 20'd64;

   // Word index sits in address bits 5:2
   localparam int WORD_IDX_W = 4;

   // Selects the upper 16 bits of a word
   localparam int HALF_BIT = 1;

endpackage

`default_nettype wire

//--- rtl/regbus_resp_mux.sv
// Response multiplexer: bank data and ack to the host, error for unmapped cycles
`timescale 1ns/10ps
`default_nettype none

module regbus_resp_mux (
   input  wire logic                                                   clk_125,
   input  wire logic                                                   core_rst_n,
   input  wire logic [regbus_pkg::NUM_REGIONS-1:0]                     bank_ack_i,
   input  wire logic [regbus_pkg::NUM_REGIONS-1:0][regbus_pkg::HOST_DAT_W-1:0] bank_dat_i,
   input  wire logic                                                   unmapped_i,
   output logic                                                        ack_o,
   output logic                                                        err_o,
   output logic      [regbus_pkg::HOST_DAT_W-1:0]                      dat_o
);

   logic err_q;

   // ****************************************
   // Error response
   // ****************************************

   // One cycle pulse, strobe during the pulse is ignored
   always_ff @(posedge clk_125 or negedge core_rst_n) begin
      if (!core_rst_n) begin
         err_q <= 1'b0;
      end else begin
         err_q <= unmapped_i & ~err_q;
      end
   end

   assign err_o = err_q;

   // ****************************************
   // Data and ack
   // ****************************************

   assign ack_o = |bank_ack_i;

   // At most one bank acks, zero when idle
   always_comb begin
      dat_o = '0;
      for (int b = 0; b < regbus_pkg::NUM_REGIONS; b++) begin
         if (bank_ack_i[b]) begin
            dat_o = dat_o | bank_dat_i[b];
         end
      end
   end

   // Decoder and banks never answer the same request twice
   resp_excl : assert property (
      @(posedge clk_125) disable iff (!core_rst_n)
      !(ack_o && err_o)
   ) else $error("ack and err raised together");

endmodule

`default_nettype wire

//--- rtl/regbus_top.sv
// Register bus top: decoder, generated half-word banks and response multiplexer
`timescale 1ns/10ps
`default_nettype none

module regbus_top (
   input  wire logic                              clk_125,
   input  wire logic                              core_rst_n,
   input  wire logic                              cyc_i,
   input  wire logic                              stb_i,
   input  wire logic                              we_i,
   input  wire logic [regbus_pkg::HOST_ADR_W-1:0] adr_i,
   input  wire logic [regbus_pkg::HOST_DAT_W-1:0] dat_i,
   input  wire logic [regbus_pkg::HOST_SEL_W-1:0] sel_i,
   output logic                                   ack_o,
   output logic                                   err_o,
   output logic      [regbus_pkg::HOST_DAT_W-1:0] dat_o
);

   logic [regbus_pkg::NUM_REGIONS-1:0]                         bank_stb;
   logic [regbus_pkg::WORD_IDX_W-1:0]                          word_idx;
   logic                                                       hi_half;
   logic                                                       unmapped;
   logic [regbus_pkg::NUM_REGIONS-1:0]                         bank_ack;
   logic [regbus_pkg::NUM_REGIONS-1:0][regbus_pkg::HOST_DAT_W-1:0] bank_dat;

   regbus_addr_decode i_addr_decode (
      .adr_i      (adr_i),
      .stb_i      (stb_i),
      .cyc_i      (cyc_i),
      .bank_stb_o (bank_stb),
      .word_idx_o (word_idx),
      .hi_half_o  (hi_half),
      .unmapped_o (unmapped)
   );

   // One bank per region
   for (genvar g = 0; g < regbus_pkg::NUM_REGIONS; g++) begin : g_bank
      regbus_half_word_bank i_bank (
         .clk_125    (clk_125),
         .core_rst_n (core_rst_n),
         .stb_i      (bank_stb[g]),
         .we_i       (we_i),
         .word_idx_i (word_idx),
         .hi_half_i  (hi_half),
         .dat_i      (dat_i),
         .sel_i      (sel_i),
         .ack_o      (bank_ack[g]),
         .dat_o      (bank_dat[g])
      );
   end

   regbus_resp_mux i_resp_mux (
      .clk_125    (clk_125),
      .core_rst_n (core_rst_n),
      .bank_ack_i (bank_ack),
      .bank_dat_i (bank_dat),
      .unmapped_i (unmapped),
      .ack_o      (ack_o),
      .err_o      (err_o),
      .dat_o      (dat_o)
   );

endmodule

`default_nettype wire

//--- verilog.f
rtl/regbus_pkg.sv
rtl/regbus_addr_decode.sv
rtl/regbus_half_word_bank.sv
rtl/regbus_resp_mux.sv
rtl/regbus_top.sv
bench/regbus_tb.sv
